//--- verilog.f
src/ppu_pkg.sv
src/ppu_cfg_decode.sv
src/gamma_corr.sv
src/test_pattern.sv
src/color_conv.sv
src/ppu_out_stage.sv
src/ppu_top.sv
test/tb_ppu_top.sv

//--- Makefile
SIM := obj_dir/Vtb_ppu_top

.PHONY: all run clean

all: $(SIM)

$(SIM): verilog.f $(wildcard src/*.sv) test/tb_ppu_top.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ppu_top -f verilog.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tb_ppu_top.sv
`timescale 1ns/1ps

module tb_ppu_top;

  localparam int PIX_LAT    = 4;
  localparam int TILE_LOG2  = 3;
  localparam int LINE_LEN   = 64;
  localparam int FRAME_LEN  = 16;
  localparam int SETTLE_MAX = 8;

  // Expected DUT outputs for one pixel slot
  typedef struct packed {
    logic [23:0] rgb;
    logic [1:0]  ncsync;
    logic [1:0]  pins;
    logic [1:0]  vclk_sel;
    logic [7:0]  state;
  } expect_t;

  logic               VCLK_Tx;
  logic               nVRST_Tx;
  ppu_pkg::vdata_t    vd_i;
  ppu_pkg::cfg_set_t  cfg_set_i;
  ppu_pkg::vmode_t    vmode_i;
  logic               use_vpll_i;
  logic               use_vga_hvsync_i;
  ppu_pkg::vdata_t    vd_o;
  logic [1:0]         ncsync_o;
  logic               nvsync_or_f2_o;
  logic               nhsync_or_f1_o;
  ppu_pkg::linemult_e vclk_sel_o;
  logic [7:0]         ppu_state_o;

  // Requested settings that go out on the next falling edge
  ppu_pkg::cfg_set_t cur_set;
  ppu_pkg::vmode_t   cur_vmode;
  logic              cur_vpll;
  logic              cur_vga;

  // Reference pipeline
  expect_t     exp_q[$];
  expect_t     exp_now;
  logic        chk_on;
  int          skip_cnt;
  int          hpos;
  int          line_no;
  logic        use_fixed;
  logic [23:0] fixed_rgb;
  string       test_name;
  logic [27:0] vd_o_bits;

  assign vd_o_bits = vd_o;

  ppu_top #(
    .BLOCK_LOG2 (TILE_LOG2)
  ) dut_i (
    .VCLK_Tx          (VCLK_Tx),
    .nVRST_Tx         (nVRST_Tx),
    .vd_i             (vd_i),
    .cfg_set_i        (cfg_set_i),
    .vmode_i          (vmode_i),
    .use_vpll_i       (use_vpll_i),
    .use_vga_hvsync_i (use_vga_hvsync_i),
    .vd_o             (vd_o),
    .ncsync_o         (ncsync_o),
    .nvsync_or_f2_o   (nvsync_or_f2_o),
    .nhsync_or_f1_o   (nhsync_or_f1_o),
    .vclk_sel_o       (vclk_sel_o),
    .ppu_state_o      (ppu_state_o)
  );

  // 8 ns pixel clock
  initial begin
    VCLK_Tx = 1'b0;
    forever #4 VCLK_Tx = ~VCLK_Tx;
  end

  // ----------------------------------------
  // Failure reporting
  // ----------------------------------------

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic report_mismatch(string sig, logic [31:0] exp, logic [31:0] act);
    $display("Fail %s %s: expected %h, actual %h", test_name, sig, exp, act);
    abort_run();
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  function automatic logic [7:0] gamma_curve(ppu_pkg::gamma_e g, logic [7:0] x);
    int v;
    v = int'(x);
    case (g)
      ppu_pkg::G_DARK:   return 8'((v * v) / 255);
      ppu_pkg::G_BRIGHT: return 8'(255 - ((255 - v) * (255 - v)) / 255);
      default:           return x;
    endcase
  endfunction

  // Division by 256 rounded toward minus infinity
  function automatic int floor_div256(int v);
    if (v >= 0)
      return v / 256;
    return -((255 - v) / 256);
  endfunction

  function automatic logic [1:0] decode_linemult();
    logic [1:0] lm;
    if (cur_set.show_testpat) begin
      lm = ppu_pkg::LM_X1;
    end else if (cur_vmode.v480i) begin
      lm = cur_set.linex2_480i ? ppu_pkg::LM_X2 : ppu_pkg::LM_X1;
    end else begin
      lm = cur_set.lm_240p;
      // X3 needs NTSC and the video PLL
      if (lm == ppu_pkg::LM_X3 && (cur_vmode.pal || !cur_vpll))
        lm = ppu_pkg::LM_X2;
    end
    return lm;
  endfunction

  function automatic logic [1:0] code_for_filter(logic [1:0] lm);
    case (cur_set.filter)
      ppu_pkg::F_SD:     return 2'b00;
      ppu_pkg::F_ED:     return 2'b01;
      ppu_pkg::F_BYPASS: return 2'b11;
      default:           return lm;
    endcase
  endfunction

  function automatic expect_t expected_out(ppu_pkg::vdata_t p, int hp, int ln);
    expect_t         e;
    ppu_pkg::gamma_e g;
    logic [1:0]      lm;
    logic [1:0]      code;
    int              r;
    int              gr;
    int              b;
    int              y;
    int              pb;
    int              pr;
    int              tmp;
    lm   = decode_linemult();
    code = code_for_filter(lm);
    g    = (cur_vmode.v480i && !cur_set.sl_linked_480i) ? cur_set.gamma_480i : cur_set.gamma;
    if (cur_set.show_testpat) begin
      // Checkerboard from the generator's own position
      r  = (((hp >> TILE_LOG2) ^ (ln >> TILE_LOG2)) & 1) != 0 ? 255 : 0;
      gr = r;
      b  = r;
    end else begin
      r  = int'(gamma_curve(g, p.r));
      gr = int'(gamma_curve(g, p.g));
      b  = int'(gamma_curve(g, p.b));
    end
    if (cur_set.ypbpr_en) begin
      y  = floor_div256(77 * r + 150 * gr + 29 * b);
      pb = 128 + floor_div256(-43 * r - 85 * gr + 128 * b);
      pr = 128 + floor_div256(128 * r - 107 * gr - 21 * b);
      r  = y;
      gr = pb;
      b  = pr;
    end
    if (cur_set.exchange_rb) begin
      tmp = r;
      r   = b;
      b   = tmp;
    end
    e.rgb      = {8'(r), 8'(gr), 8'(b)};
    e.ncsync   = {p.sync.ncsync, (cur_set.ypbpr_en | cur_set.rgsb_en) & p.sync.ncsync};
    e.pins     = cur_vga ? {p.sync.nvsync, p.sync.nhsync} : {code[0], code[1]};
    e.vclk_sel = lm;
    e.state    = {cur_vmode.pal, cur_vmode.v480i, lm, cur_set.ypbpr_en, cur_set.rgsb_en,
                  cur_set.filter == ppu_pkg::F_AUTO, cur_set.show_testpat};
    return e;
  endfunction

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  function automatic logic [23:0] next_colour();
    if (use_fixed)
      return fixed_rgb;
    return 24'($urandom);
  endfunction

  // Drives one pixel per falling edge and queues its expectation
  task automatic drive_pixel();
    ppu_pkg::vdata_t p;
    expect_t         blank;
    logic            changed;
    @(negedge VCLK_Tx);
    blank   = '0;
    p       = '0;
    changed = (cur_set != cfg_set_i) || (cur_vmode != vmode_i) ||
              (cur_vpll != use_vpll_i) || (cur_vga != use_vga_hvsync_i);
    if (nVRST_Tx) begin
      p.sync.nhsync = (hpos >= 4);
      p.sync.nvsync = (line_no >= 2);
      p.sync.ncsync = p.sync.nhsync & p.sync.nvsync;
      p.sync.nclamp = !(hpos >= 6 && hpos < 12);
      {p.r, p.g, p.b} = next_colour();
    end
    cfg_set_i        = cur_set;
    vmode_i          = cur_vmode;
    use_vpll_i       = cur_vpll;
    use_vga_hvsync_i = cur_vga;
    vd_i             = p;
    // Entry leaving now belongs to the pixel four slots back
    exp_now = exp_q.pop_front();
    chk_on  = (skip_cnt == 0);
    if (skip_cnt > 0)
      skip_cnt--;
    if (nVRST_Tx)
      exp_q.push_back(expected_out(p, hpos, line_no));
    else
      exp_q.push_back(blank);
    // Pixels in flight saw mixed settings
    if (changed)
      skip_cnt = PIX_LAT;
    if (nVRST_Tx) begin
      if (hpos == LINE_LEN - 1) begin
        hpos    = 0;
        line_no = (line_no == FRAME_LEN - 1) ? 0 : line_no + 1;
      end else begin
        hpos++;
      end
    end
  endtask

  task automatic run_pixels(int n);
    repeat (n) drive_pixel();
  endtask

  // Drive new settings and wait until the decoder shows them
  task automatic apply_settings();
    ppu_pkg::vdata_t zero_pix;
    expect_t         want;
    int              n;
    zero_pix = '0;
    want     = expected_out(zero_pix, 0, 0);
    n        = 0;
    drive_pixel();
    while (ppu_state_o != want.state || vclk_sel_o != want.vclk_sel) begin
      if (n == SETTLE_MAX) begin
        $display("Settings not applied within %0d cycles in %s", SETTLE_MAX, test_name);
        abort_run();
      end
      drive_pixel();
      n++;
    end
  endtask

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  vd_check: assert property (@(posedge VCLK_Tx) !chk_on || vd_o_bits == {4'h0, exp_now.rgb})
    else report_mismatch("vd_o", 32'({4'h0, exp_now.rgb}), 32'($sampled(vd_o_bits)));

  csync_check: assert property (@(posedge VCLK_Tx) !chk_on || ncsync_o == exp_now.ncsync)
    else report_mismatch("ncsync_o", 32'(exp_now.ncsync), 32'($sampled(ncsync_o)));

  pins_check: assert property (@(posedge VCLK_Tx)
      !chk_on || {nvsync_or_f2_o, nhsync_or_f1_o} == exp_now.pins)
    else report_mismatch("sync_or_filter", 32'(exp_now.pins),
                         32'({$sampled(nvsync_or_f2_o), $sampled(nhsync_or_f1_o)}));

  sel_check: assert property (@(posedge VCLK_Tx) !chk_on || vclk_sel_o == exp_now.vclk_sel)
    else report_mismatch("vclk_sel_o", 32'(exp_now.vclk_sel), 32'($sampled(vclk_sel_o)));

  state_check: assert property (@(posedge VCLK_Tx) !chk_on || ppu_state_o == exp_now.state)
    else report_mismatch("ppu_state_o", 32'(exp_now.state), 32'($sampled(ppu_state_o)));

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    void'($urandom(32'h3184));
    nVRST_Tx         = 1'b0;
    vd_i             = '0;
    cfg_set_i        = '0;
    // SD filter keeps the status word at zero
    cfg_set_i.filter = ppu_pkg::F_SD;
    vmode_i          = '0;
    use_vpll_i       = 1'b0;
    use_vga_hvsync_i = 1'b0;
    cur_set          = cfg_set_i;
    cur_vmode        = '0;
    cur_vpll         = 1'b0;
    cur_vga          = 1'b0;
    exp_now          = '0;
    chk_on           = 1'b0;
    skip_cnt         = 0;
    hpos             = 0;
    line_no          = 0;
    use_fixed        = 1'b0;
    fixed_rgb        = '0;
    repeat (PIX_LAT) exp_q.push_back(exp_now);

    test_name = "reset";
    run_pixels(5);
    nVRST_Tx = 1'b1;
    run_pixels(PIX_LAT + 4);

    // Gamma curves with and without red/blue exchange
    for (int g = 0; g < 3; g++) begin
      for (int x = 0; x < 2; x++) begin
        test_name           = $sformatf("gamma_%0d_xrb_%0d", g, x);
        cur_set.gamma       = ppu_pkg::gamma_e'(g);
        cur_set.exchange_rb = x[0];
        apply_settings();
        run_pixels(40);
      end
    end

    // YPbPr matrix starting with black and white
    for (int x = 0; x < 2; x++) begin
      test_name           = $sformatf("ypbpr_xrb_%0d", x);
      cur_set.gamma       = ppu_pkg::G_LINEAR;
      cur_set.exchange_rb = x[0];
      cur_set.ypbpr_en    = 1'b1;
      apply_settings();
      use_fixed = 1'b1;
      fixed_rgb = 24'h000000;
      run_pixels(1);
      fixed_rgb = 24'hffffff;
      run_pixels(1);
      use_fixed = 1'b0;
      run_pixels(60);
    end

    // Decoder sweep over mode, PLL, multiplier and filter
    cur_set.ypbpr_en    = 1'b0;
    cur_set.exchange_rb = 1'b0;
    cur_set.gamma       = ppu_pkg::G_DARK;
    cur_set.gamma_480i  = ppu_pkg::G_BRIGHT;
    for (int vm = 0; vm < 4; vm++) begin
      for (int vp = 0; vp < 2; vp++) begin
        for (int lm = 0; lm < 3; lm++) begin
          for (int lx = 0; lx < 2; lx++) begin
            for (int f = 0; f < 4; f++) begin
              test_name = $sformatf("decode_m%0d_p%0d_lm%0d_x%0d_f%0d", vm, vp, lm, lx, f);
              cur_vmode              = vm[1:0];
              cur_vpll               = vp[0];
              cur_set.lm_240p        = ppu_pkg::linemult_e'(lm);
              cur_set.linex2_480i    = lx[0];
              cur_set.sl_linked_480i = lx[0] ^ vp[0];
              cur_set.filter         = ppu_pkg::filter_e'(f);
              cur_set.rgsb_en        = f[0];
              apply_settings();
              run_pixels(6);
            end
          end
        end
      end
    end

    // Checkerboard with X3 requested falls back to X1
    test_name            = "test_pattern";
    cur_vmode            = '0;
    cur_vpll             = 1'b1;
    cur_set.lm_240p      = ppu_pkg::LM_X3;
    cur_set.filter       = ppu_pkg::F_AUTO;
    cur_set.show_testpat = 1'b1;
    apply_settings();
    run_pixels(2 * LINE_LEN * FRAME_LEN);

    // VGA sync on the shared pins
    test_name            = "vga_sync_rgb";
    cur_set.show_testpat = 1'b0;
    cur_set.rgsb_en      = 1'b0;
    cur_set.gamma        = ppu_pkg::G_LINEAR;
    cur_vga              = 1'b1;
    apply_settings();
    run_pixels(LINE_LEN * FRAME_LEN);
    test_name       = "vga_sync_rgsb";
    cur_set.rgsb_en = 1'b1;
    apply_settings();
    run_pixels(2 * LINE_LEN);

    // Let the last pixels reach the output
    run_pixels(PIX_LAT + 2);
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- src/ppu_top.sv
`timescale 1ns/1ps

module ppu_top #(
  parameter int BLOCK_LOG2 = 3
) (
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,
  input  ppu_pkg::vdata_t    vd_i,
  input  ppu_pkg::cfg_set_t  cfg_set_i,
  input  ppu_pkg::vmode_t    vmode_i,
  input  logic               use_vpll_i,
  input  logic               use_vga_hvsync_i,
  output ppu_pkg::vdata_t    vd_o,
  output logic [1:0]         ncsync_o,
  output logic               nvsync_or_f2_o,
  output logic               nhsync_or_f1_o,
  output ppu_pkg::linemult_e vclk_sel_o,
  output logic [7:0]         ppu_state_o
);

  ppu_pkg::cfg_t   cfg;
  ppu_pkg::vdata_t vd_gamma;
  ppu_pkg::vdata_t vd_tp;
  ppu_pkg::vdata_t vd_sel;
  ppu_pkg::vdata_t vd_conv;

  // ----------------------------------------
  // Settings
  // ----------------------------------------

  ppu_cfg_decode cfg_decode_i (
    .VCLK_Tx     (VCLK_Tx),
    .nVRST_Tx    (nVRST_Tx),
    .cfg_set_i   (cfg_set_i),
    .vmode_i     (vmode_i),
    .use_vpll_i  (use_vpll_i),
    .cfg_o       (cfg),
    .vclk_sel_o  (vclk_sel_o),
    .ppu_state_o (ppu_state_o)
  );

  // ----------------------------------------
  // Pixel pipeline
  // ----------------------------------------

  // Both sources are one cycle deep
  gamma_corr gamma_i (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .gamma_i  (cfg.gamma),
    .vd_i     (vd_i),
    .vd_o     (vd_gamma)
  );

  test_pattern #(
    .BLOCK_LOG2 (BLOCK_LOG2)
  ) test_pattern_i (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .vd_i     (vd_i),
    .vd_o     (vd_tp)
  );

  // Pattern replaces the video when enabled
  assign vd_sel = cfg.testpat ? vd_tp : vd_gamma;

  color_conv color_conv_i (
    .VCLK_Tx    (VCLK_Tx),
    .nVRST_Tx   (nVRST_Tx),
    .ypbpr_en_i (cfg.ypbpr_en),
    .vd_i       (vd_sel),
    .vd_o       (vd_conv)
  );

  ppu_out_stage out_stage_i (
    .VCLK_Tx          (VCLK_Tx),
    .nVRST_Tx         (nVRST_Tx),
    .cfg_i            (cfg),
    .use_vga_hvsync_i (use_vga_hvsync_i),
    .vd_i             (vd_conv),
    .vd_o             (vd_o),
    .ncsync_o         (ncsync_o),
    .nvsync_or_f2_o   (nvsync_or_f2_o),
    .nhsync_or_f1_o   (nhsync_or_f1_o)
  );

endmodule

//--- src/ppu_out_stage.sv
`timescale 1ns/1ps

module ppu_out_stage (
  input  logic            VCLK_Tx,
  input  logic            nVRST_Tx,
  input  ppu_pkg::cfg_t   cfg_i,
  input  logic            use_vga_hvsync_i,
  input  ppu_pkg::vdata_t vd_i,
  output ppu_pkg::vdata_t vd_o,
  output logic [1:0]      ncsync_o,
  output logic            nvsync_or_f2_o,
  output logic            nhsync_or_f1_o
);

  // ----------------------------------------
  // Colour and composite sync
  // ----------------------------------------

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vd_o     <= '0;
      ncsync_o <= 2'b00;
    end else begin
      // Sync is carried on the dedicated pins only
      vd_o.sync <= '0;
      vd_o.g    <= vd_i.g;
      if (cfg_i.exchange_rb) begin
        vd_o.r <= vd_i.b;
        vd_o.b <= vd_i.r;
      end else begin
        vd_o.r <= vd_i.r;
        vd_o.b <= vd_i.b;
      end

      ncsync_o[1] <= vd_i.sync.ncsync;
      // Held low for plain RGB
      ncsync_o[0] <= cfg_i.csync0_en ? vd_i.sync.ncsync : 1'b0;
    end
  end

  // ----------------------------------------
  // VGA sync or filter add-on pins
  // ----------------------------------------

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      nvsync_or_f2_o <= 1'b0;
      nhsync_or_f1_o <= 1'b0;
    end else if (use_vga_hvsync_i) begin
      nvsync_or_f2_o <= vd_i.sync.nvsync;
      nhsync_or_f1_o <= vd_i.sync.nhsync;
    end else begin
      // F1 takes the MSB of the code
      nvsync_or_f2_o <= cfg_i.filter_code[0];
      nhsync_or_f1_o <= cfg_i.filter_code[1];
    end
  end

endmodule

//--- src/color_conv.sv
`timescale 1ns/1ps

module color_conv (
  input  logic            VCLK_Tx,
  input  logic            nVRST_Tx,
  input  logic            ypbpr_en_i,
  input  ppu_pkg::vdata_t vd_i,
  output ppu_pkg::vdata_t vd_o
);

  localparam int PRD_W = 2*ppu_pkg::COLOR_W + 2;
  localparam int SUM_W = PRD_W + 2;

  // Rows Y, Pb, Pr; columns R, G, B; scaled by 256
  localparam logic signed [PRD_W-1:0] COEF [9] = '{
    18'sd77,   18'sd150,  18'sd29,
    -18'sd43,  -18'sd85,  18'sd128,
    18'sd128,  -18'sd107, -18'sd21
  };

  // Chroma sits around mid-scale
  localparam logic [ppu_pkg::COLOR_W-1:0] OFS [3] = '{8'd0, 8'd128, 8'd128};

  logic signed [PRD_W-1:0] prod_q [9];
  ppu_pkg::vdata_t         vd_q;
  logic                    en_q;
  logic [ppu_pkg::COLOR_W-1:0] conv [3];

  // ----------------------------------------
  // Stage one, products
  // ----------------------------------------

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < 9; i++)
        prod_q[i] <= '0;
      vd_q <= '0;
      en_q <= 1'b0;
    end else begin
      for (int k = 0; k < 3; k++) begin
        prod_q[3*k]   <= $signed({10'd0, vd_i.r}) * COEF[3*k];
        prod_q[3*k+1] <= $signed({10'd0, vd_i.g}) * COEF[3*k+1];
        prod_q[3*k+2] <= $signed({10'd0, vd_i.b}) * COEF[3*k+2];
      end
      // Raw pixel rides along for the bypass
      vd_q <= vd_i;
      en_q <= ypbpr_en_i;
    end
  end

  // ----------------------------------------
  // Stage two, sums
  // ----------------------------------------

  always_comb begin
    logic signed [SUM_W-1:0] sum;
    logic signed [SUM_W-1:0] shr;
    for (int k = 0; k < 3; k++) begin
      sum = SUM_W'(prod_q[3*k]) + SUM_W'(prod_q[3*k+1]) + SUM_W'(prod_q[3*k+2]);
      // Arithmetic shift floors toward minus infinity
      shr = sum >>> 8;
      conv[k] = shr[ppu_pkg::COLOR_W-1:0] + OFS[k];
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vd_o <= '0;
    end else begin
      vd_o.sync <= vd_q.sync;
      if (en_q) begin
        vd_o.r <= conv[0];
        vd_o.g <= conv[1];
        vd_o.b <= conv[2];
      end else begin
        vd_o.r <= vd_q.r;
        vd_o.g <= vd_q.g;
        vd_o.b <= vd_q.b;
      end
    end
  end

endmodule

//--- src/test_pattern.sv
`timescale 1ns/1ps

module test_pattern #(
  parameter int BLOCK_LOG2 = 3
) (
  input  logic            VCLK_Tx,
  input  logic            nVRST_Tx,
  input  ppu_pkg::vdata_t vd_i,
  output ppu_pkg::vdata_t vd_o
);

  localparam int CNT_W = 12;

  logic             nhsync_q;
  logic             nvsync_q;
  logic             h_fall;
  logic             v_fall;
  logic [CNT_W-1:0] pix_cnt;
  logic [CNT_W-1:0] line_cnt;
  logic [CNT_W-1:0] pix_nxt;
  logic [CNT_W-1:0] line_nxt;
  logic             tile_on;

  // ----------------------------------------
  // Position counters
  // ----------------------------------------

  // Falling edges start a new line or frame
  assign h_fall = nhsync_q & ~vd_i.sync.nhsync;
  assign v_fall = nvsync_q & ~vd_i.sync.nvsync;

  // Pixel at the edge itself is position zero
  assign pix_nxt = h_fall ? '0 : pix_cnt + 1'b1;

  always_comb begin
    if (v_fall)
      line_nxt = '0;
    else if (h_fall)
      line_nxt = line_cnt + 1'b1;
    else
      line_nxt = line_cnt;
  end

  // Checkerboard of 2**BLOCK_LOG2 square tiles
  assign tile_on = pix_nxt[BLOCK_LOG2] ^ line_nxt[BLOCK_LOG2];

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      // Sync idles high
      nhsync_q <= 1'b1;
      nvsync_q <= 1'b1;
      pix_cnt  <= '0;
      line_cnt <= '0;
      vd_o     <= '0;
    end else begin
      nhsync_q  <= vd_i.sync.nhsync;
      nvsync_q  <= vd_i.sync.nvsync;
      pix_cnt   <= pix_nxt;
      line_cnt  <= line_nxt;
      vd_o.sync <= vd_i.sync;
      vd_o.r    <= {ppu_pkg::COLOR_W{tile_on}};
      vd_o.g    <= {ppu_pkg::COLOR_W{tile_on}};
      vd_o.b    <= {ppu_pkg::COLOR_W{tile_on}};
    end
  end

endmodule

//--- src/gamma_corr.sv
`timescale 1ns/1ps

module gamma_corr (
  input  logic            VCLK_Tx,
  input  logic            nVRST_Tx,
  input  ppu_pkg::gamma_e gamma_i,
  input  ppu_pkg::vdata_t vd_i,
  output ppu_pkg::vdata_t vd_o
);

  // ----------------------------------------
  // Curves
  // ----------------------------------------

  // Square law around either end of the range
  function automatic logic [ppu_pkg::COLOR_W-1:0] curve(
    input ppu_pkg::gamma_e               g,
    input logic [ppu_pkg::COLOR_W-1:0]   x
  );
    logic [ppu_pkg::COLOR_W-1:0]   inv;
    logic [2*ppu_pkg::COLOR_W-1:0] sq;
    logic [2*ppu_pkg::COLOR_W-1:0] quo;
    inv = ~x;
    case (g)
      ppu_pkg::G_DARK: begin
        sq  = x * x;
        quo = sq / 16'd255;
        return quo[ppu_pkg::COLOR_W-1:0];
      end
      ppu_pkg::G_BRIGHT: begin
        // 255 - x is the bitwise inverse
        sq  = inv * inv;
        quo = sq / 16'd255;
        return ~quo[ppu_pkg::COLOR_W-1:0];
      end
      default: begin
        return x;
      end
    endcase
  endfunction

  // ----------------------------------------
  // Pixel register
  // ----------------------------------------

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vd_o <= '0;
    end else begin
      // Sync passes untouched
      vd_o.sync <= vd_i.sync;
      vd_o.r    <= curve(gamma_i, vd_i.r);
      vd_o.g    <= curve(gamma_i, vd_i.g);
      vd_o.b    <= curve(gamma_i, vd_i.b);
    end
  end

endmodule

//--- src/ppu_cfg_decode.sv
`timescale 1ns/1ps

module ppu_cfg_decode (
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,
  input  ppu_pkg::cfg_set_t  cfg_set_i,
  input  ppu_pkg::vmode_t    vmode_i,
  input  logic               use_vpll_i,
  output ppu_pkg::cfg_t      cfg_o,
  output ppu_pkg::linemult_e vclk_sel_o,
  output logic [7:0]         ppu_state_o
);

  ppu_pkg::cfg_t      cfg_nxt;
  ppu_pkg::linemult_e lm_nxt;
  logic               auto_filter;

  // ----------------------------------------
  // Line multiplier
  // ----------------------------------------

  always_comb begin
    if (cfg_set_i.show_testpat) begin
      // Test pattern is generated at native rate
      lm_nxt = ppu_pkg::LM_X1;
    end else if (vmode_i.v480i) begin
      lm_nxt = cfg_set_i.linex2_480i ? ppu_pkg::LM_X2 : ppu_pkg::LM_X1;
    end else if (vmode_i.pal || !use_vpll_i) begin
      // No X3 in PAL or without the video PLL
      if (cfg_set_i.lm_240p == ppu_pkg::LM_X1)
        lm_nxt = ppu_pkg::LM_X1;
      else
        lm_nxt = ppu_pkg::LM_X2;
    end else begin
      lm_nxt = cfg_set_i.lm_240p;
    end
  end

  assign auto_filter = (cfg_set_i.filter == ppu_pkg::F_AUTO);

  // ----------------------------------------
  // Working settings
  // ----------------------------------------

  always_comb begin
    cfg_nxt             = '0;
    cfg_nxt.testpat     = cfg_set_i.show_testpat;
    cfg_nxt.exchange_rb = cfg_set_i.exchange_rb;
    cfg_nxt.ypbpr_en    = cfg_set_i.ypbpr_en;
    // Second csync pin only for sync-on-green or YPbPr
    cfg_nxt.csync0_en   = cfg_set_i.ypbpr_en | cfg_set_i.rgsb_en;
    cfg_nxt.linemult    = lm_nxt;

    // 480i may use its own curve unless linked to 240p
    if (vmode_i.v480i && !cfg_set_i.sl_linked_480i)
      cfg_nxt.gamma = cfg_set_i.gamma_480i;
    else
      cfg_nxt.gamma = cfg_set_i.gamma;

    // Add-on code, F1 is the MSB
    case (cfg_set_i.filter)
      ppu_pkg::F_AUTO:   cfg_nxt.filter_code = lm_nxt;
      ppu_pkg::F_SD:     cfg_nxt.filter_code = 2'b00;
      ppu_pkg::F_ED:     cfg_nxt.filter_code = 2'b01;
      ppu_pkg::F_BYPASS: cfg_nxt.filter_code = 2'b11;
      default:           cfg_nxt.filter_code = 2'b00;
    endcase
  end

  // Register settings and status together
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      cfg_o       <= '0;
      ppu_state_o <= 8'h00;
    end else begin
      cfg_o       <= cfg_nxt;
      ppu_state_o <= {vmode_i.pal, vmode_i.v480i, lm_nxt, cfg_set_i.ypbpr_en,
                      cfg_set_i.rgsb_en, auto_filter, cfg_set_i.show_testpat};
    end
  end

  // Tx clock follows the registered multiplier
  assign vclk_sel_o = cfg_o.linemult;

endmodule

//--- src/ppu_pkg.sv
package ppu_pkg;

  // ----------------------------------------
  // Widths and latencies
  // ----------------------------------------

  // One colour channel
  localparam int COLOR_W = 8;

  // Cycles from the top-level pixel input to vd_o
  localparam int PIX_LAT = 4;

  // ----------------------------------------
  // Pixel
  // ----------------------------------------

  // Sync bits of the N64 stream, all active low
  typedef struct packed {
    logic nvsync;
    logic nclamp;
    logic nhsync;
    logic ncsync;
  } sync_t;

  // One pixel; in YPbPr mode r, g, b carry Y, Pb, Pr
  typedef struct packed {
    sync_t              sync;
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } vdata_t;

  // ----------------------------------------
  // Configuration encodings
  // ----------------------------------------

  typedef enum logic [1:0] {
    G_LINEAR = 2'd0,
    G_DARK   = 2'd1,
    G_BRIGHT = 2'd2
  } gamma_e;

  // Line multiplier, also the Tx clock select
  typedef enum logic [1:0] {
    LM_X1 = 2'd0,
    LM_X2 = 2'd1,
    LM_X3 = 2'd2
  } linemult_e;

  // Filter add-on selection from the menu
  typedef enum logic [1:0] {
    F_AUTO   = 2'd0,
    F_SD     = 2'd1,
    F_ED     = 2'd2,
    F_BYPASS = 2'd3
  } filter_e;

  // Raw settings as delivered by the controller
  typedef struct packed {
    logic      show_testpat;
    logic      exchange_rb;
    filter_e   filter;
    logic      ypbpr_en;
    logic      rgsb_en;
    gamma_e    gamma;
    linemult_e lm_240p;
    logic      linex2_480i;
    logic      sl_linked_480i;
    gamma_e    gamma_480i;
  } cfg_set_t;

  // Working settings after mode decode
  typedef struct packed {
    logic       testpat;
    logic       exchange_rb;
    logic [1:0] filter_code;
    logic       ypbpr_en;
    logic       csync0_en;
    gamma_e     gamma;
    linemult_e  linemult;
  } cfg_t;

  // Current video mode
  typedef struct packed {
    logic pal;
    logic v480i;
  } vmode_t;

endpackage
